//--- rtl/decoder_control_top.sv
module decoder_control_top #(
    parameter int grid_width_x            = 4,
    parameter int grid_width_z            = 1,
    parameter int grid_width_u            = 5,
    parameter int iteration_counter_width = 8,
    parameter int maximum_delay           = 2,
    localparam int pu_count_per_round     = grid_width_x * grid_width_z,
    localparam int pu_count               = pu_count_per_round * grid_width_u,
    localparam int aligned_pu_per_round   = ((pu_count_per_round + 7) / 8) * 8,
    localparam int correction_count_per_round =
        (grid_width_x - 1) * grid_width_z + (grid_width_x - 1) * grid_width_z + 1
        + grid_width_x * grid_width_z
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  decoder_pkg::byte_t                    input_data,
    input  logic                                  input_valid,
    output logic                                  input_ready,
    output decoder_pkg::byte_t                    output_data,
    output logic                                  output_valid,
    input  logic                                  output_ready,
    input  logic [pu_count-1:0]                   busy_pe,
    input  logic [pu_count-1:0]                   odd_clusters_pe,
    output logic [aligned_pu_per_round-1:0]       measurements,
    input  logic [correction_count_per_round-1:0] correction,
    output decoder_pkg::global_stage_t            global_stage
);

    unified_controller #(
        .grid_width_x(grid_width_x),
        .grid_width_z(grid_width_z),
        .grid_width_u(grid_width_u),
        .iteration_counter_width(iteration_counter_width),
        .maximum_delay(maximum_delay)
    ) u_controller (
        .clk(clk),
        .reset(reset),
        .input_data(input_data),
        .input_valid(input_valid),
        .input_ready(input_ready),
        .output_data(output_data),
        .output_valid(output_valid),
        .output_ready(output_ready),
        .busy_pe(busy_pe),
        .odd_clusters_pe(odd_clusters_pe),
        .measurements(measurements),
        .correction(correction),
        .global_stage(global_stage)
    );

endmodule

//--- rtl/decoder_pkg.sv
package decoder_pkg;

    // stage broadcast to the processing-element array
    typedef enum logic [3:0] {
        idle                  = 4'd0,
        grow                  = 4'd2,
        merge                 = 4'd3,
        peeling               = 4'd4,
        result_valid          = 4'd5,
        parameters_loading    = 4'd6,
        measurement_preparing = 4'd7,
        measurement_loading   = 4'd8,
        streaming_correction  = 4'd9
    } global_stage_t;

    typedef logic [7:0] byte_t;  // one byte of a host message

    // host message codes, recognized only while the stage is idle
    localparam byte_t start_decoding_msg      = 8'h01;
    localparam byte_t measurement_data_header = 8'h02;

endpackage

//--- rtl/fifo_wrapper.sv
module fifo_wrapper #(
    parameter int width = 8,
    parameter int depth = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [width-1:0] input_data,
    input  logic             input_valid,
    output logic             input_ready,
    output logic [width-1:0] output_data,
    output logic             output_valid,
    input  logic             output_ready
);

    localparam int addr_width  = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    logic [width-1:0]       mem [depth];
    logic [addr_width-1:0]  wr_ptr;
    logic [addr_width-1:0]  rd_ptr;
    logic [count_width-1:0] count;
    logic                   push;
    logic                   pop;

    assign input_ready  = (count != count_width'(depth));
    assign output_valid = (count != '0);
    assign output_data  = mem[rd_ptr];  // head word is visible before it is popped
    assign push         = input_valid && input_ready;
    assign pop          = output_valid && output_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= input_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == addr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == addr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- rtl/serializer.sv
module serializer #(
    parameter int wide_width = 11
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [wide_width-1:0] wide_data,
    input  logic                  wide_valid,
    output logic                  wide_ready,
    output decoder_pkg::byte_t    narrow_data,
    output logic                  narrow_valid,
    input  logic                  narrow_ready
);

    localparam int bytes_per_word = (wide_width + 7) / 8;
    localparam int padded_width   = bytes_per_word * 8;
    localparam int index_width    = $clog2(bytes_per_word + 1);

    logic [padded_width-1:0] wide_padded;
    logic [padded_width-1:0] word_reg;
    logic [index_width-1:0]  byte_index;
    logic                    holding;

    assign wide_padded  = padded_width'(wide_data);  // upper bits come out as zero
    assign wide_ready   = !holding;
    assign narrow_valid = holding;
    assign narrow_data  = word_reg[7:0];

    // the word shifts down so the current byte always sits at the bottom
    always_ff @(posedge clk) begin
        if (wide_valid && wide_ready) begin
            word_reg <= wide_padded;
        end else if (narrow_valid && narrow_ready) begin
            word_reg <= word_reg >> 8;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            holding    <= 1'b0;
            byte_index <= '0;
        end else if (wide_valid && wide_ready) begin
            holding    <= 1'b1;
            byte_index <= '0;
        end else if (narrow_valid && narrow_ready) begin
            if (byte_index == index_width'(bytes_per_word - 1)) begin
                holding    <= 1'b0;  // word fully sent, free for the next one
                byte_index <= '0;
            end else begin
                byte_index <= byte_index + 1'b1;
            end
        end
    end

endmodule

//--- rtl/unified_controller.sv
module unified_controller #(
    parameter int grid_width_x            = 4,
    parameter int grid_width_z            = 1,
    parameter int grid_width_u            = 5,
    parameter int iteration_counter_width = 8,
    parameter int maximum_delay           = 2,
    localparam int pu_count_per_round     = grid_width_x * grid_width_z,
    localparam int pu_count               = pu_count_per_round * grid_width_u,
    localparam int bytes_per_round        = (pu_count_per_round + 7) / 8,
    localparam int aligned_pu_per_round   = bytes_per_round * 8,
    localparam int correction_count_per_round =
        (grid_width_x - 1) * grid_width_z + (grid_width_x - 1) * grid_width_z + 1
        + grid_width_x * grid_width_z
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  decoder_pkg::byte_t                    input_data,
    input  logic                                  input_valid,
    output logic                                  input_ready,
    output decoder_pkg::byte_t                    output_data,
    output logic                                  output_valid,
    input  logic                                  output_ready,
    input  logic [pu_count-1:0]                   busy_pe,
    input  logic [pu_count-1:0]                   odd_clusters_pe,
    output logic [aligned_pu_per_round-1:0]       measurements,
    input  logic [correction_count_per_round-1:0] correction,
    output decoder_pkg::global_stage_t            global_stage
);

    localparam int rounds_per_decode   = grid_width_u / 2;
    localparam int bytes_per_word      = (correction_count_per_round + 7) / 8;
    localparam int output_bytes        = 3 + bytes_per_word * rounds_per_decode;
    localparam int delay_width         = $clog2(maximum_delay + 1);
    localparam int msg_count_width     = $clog2(bytes_per_round + 1);
    localparam int round_count_width   = $clog2(rounds_per_decode + 1);
    localparam int out_count_width     = $clog2(output_bytes);

    typedef logic [correction_count_per_round-1:0] correction_t;
    typedef logic [15:0] cycle_count_t;

    decoder_pkg::global_stage_t      stage_d;
    logic                            busy;
    logic                            odd_clusters;
    logic [iteration_counter_width-1:0] iteration_counter;
    cycle_count_t                    cycle_counter;
    logic [delay_width-1:0]          delay_counter;
    logic [msg_count_width-1:0]      msg_count;
    logic [round_count_width-1:0]    round_count;
    logic [out_count_width-1:0]      out_count;
    logic [aligned_pu_per_round+7:0] meas_shifted;
    logic                            in_fire;
    logic                            fifo_in_valid;
    correction_t                     fifo_out_data;
    logic                            fifo_out_valid;
    logic                            fifo_out_ready;
    decoder_pkg::byte_t              ser_data;
    logic                            ser_valid;
    logic                            ser_ready;
    decoder_pkg::byte_t              iteration_byte;

    assign input_ready = !reset && (global_stage == decoder_pkg::idle ||
                                    global_stage == decoder_pkg::measurement_preparing);
    assign in_fire = input_valid && input_ready;

    // array flags are registered once before the stage machine sees them
    always_ff @(posedge clk) begin
        busy         <= |busy_pe;
        odd_clusters <= |odd_clusters_pe;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_d <= decoder_pkg::idle;
        end else begin
            stage_d <= global_stage;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_counter     <= '0;
            iteration_counter <= '0;
        end else if (global_stage == decoder_pkg::measurement_loading) begin
            cycle_counter     <= 16'd1;
            iteration_counter <= '0;
        end else begin
            if (global_stage == decoder_pkg::grow || global_stage == decoder_pkg::merge ||
                global_stage == decoder_pkg::peeling) begin
                cycle_counter <= cycle_counter + 1'b1;
            end
            if (global_stage == decoder_pkg::grow && stage_d != decoder_pkg::grow) begin
                iteration_counter <= iteration_counter + 1'b1;
            end
        end
    end

    // new byte enters at the top, older bytes move towards bit 0
    assign meas_shifted = {input_data, measurements} >> 8;

    always_ff @(posedge clk) begin
        if (global_stage == decoder_pkg::measurement_preparing && in_fire) begin
            measurements <= meas_shifted[aligned_pu_per_round-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage  <= decoder_pkg::idle;
            delay_counter <= '0;
            msg_count     <= '0;
            round_count   <= '0;
        end else begin
            case (global_stage)
                decoder_pkg::idle: begin
                    if (in_fire && input_data == decoder_pkg::start_decoding_msg) begin
                        global_stage <= decoder_pkg::parameters_loading;
                    end else if (in_fire && input_data == decoder_pkg::measurement_data_header) begin
                        global_stage <= decoder_pkg::measurement_preparing;
                        msg_count    <= '0;
                        round_count  <= '0;
                    end
                end
                decoder_pkg::parameters_loading: begin
                    global_stage <= decoder_pkg::idle;
                    msg_count    <= '0;
                    round_count  <= '0;
                end
                decoder_pkg::measurement_preparing: begin
                    if (in_fire) begin
                        if (msg_count == msg_count_width'(bytes_per_round - 1)) begin
                            global_stage <= decoder_pkg::measurement_loading;
                            msg_count    <= '0;
                            round_count  <= round_count + 1'b1;
                        end else begin
                            msg_count <= msg_count + 1'b1;
                        end
                    end
                end
                decoder_pkg::measurement_loading: begin
                    delay_counter <= '0;
                    if (round_count < round_count_width'(rounds_per_decode)) begin
                        global_stage <= decoder_pkg::measurement_preparing;
                    end else begin
                        global_stage <= decoder_pkg::grow;
                    end
                end
                decoder_pkg::grow: begin
                    global_stage  <= decoder_pkg::merge;
                    delay_counter <= '0;
                    round_count   <= '0;  // reused to count result words
                end
                decoder_pkg::merge: begin
                    if (delay_counter >= delay_width'(maximum_delay)) begin
                        if (!busy) begin
                            global_stage  <= odd_clusters ? decoder_pkg::grow
                                                          : decoder_pkg::peeling;
                            delay_counter <= '0;
                        end
                    end else begin
                        delay_counter <= delay_counter + 1'b1;
                    end
                end
                decoder_pkg::peeling: begin
                    if (delay_counter >= delay_width'(maximum_delay)) begin
                        if (!busy) begin
                            global_stage  <= decoder_pkg::streaming_correction;
                            delay_counter <= '0;
                        end
                    end else begin
                        delay_counter <= delay_counter + 1'b1;
                    end
                end
                decoder_pkg::streaming_correction: begin
                    global_stage <= decoder_pkg::result_valid;
                end
                decoder_pkg::result_valid: begin
                    round_count <= round_count + 1'b1;
                    if (round_count == round_count_width'(rounds_per_decode - 1)) begin
                        global_stage <= decoder_pkg::idle;
                    end
                end
                default: global_stage <= decoder_pkg::idle;
            endcase
        end
    end

    // the array answers one cycle behind the stage it was shown
    assign fifo_in_valid = (stage_d == decoder_pkg::result_valid);

    fifo_wrapper #(
        .width(correction_count_per_round),
        .depth(32)
    ) u_output_fifo (
        .clk(clk),
        .reset(reset),
        .input_data(correction),
        .input_valid(fifo_in_valid),
        .input_ready(),  // depth far exceeds the words of one decode
        .output_data(fifo_out_data),
        .output_valid(fifo_out_valid),
        .output_ready(fifo_out_ready)
    );

    serializer #(
        .wide_width(correction_count_per_round)
    ) u_serializer (
        .clk(clk),
        .reset(reset),
        .wide_data(fifo_out_data),
        .wide_valid(fifo_out_valid),
        .wide_ready(fifo_out_ready),
        .narrow_data(ser_data),
        .narrow_valid(ser_valid),
        .narrow_ready(ser_ready)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_count <= '0;
        end else if (output_valid && output_ready) begin
            if (out_count == out_count_width'(output_bytes - 1)) begin
                out_count <= '0;
            end else begin
                out_count <= out_count + 1'b1;
            end
        end
    end

    assign iteration_byte = decoder_pkg::byte_t'(iteration_counter);
    assign output_valid   = ser_valid;

    // header goes out first while the serializer holds its word
    always_comb begin
        output_data = ser_data;
        ser_ready   = output_ready;
        case (out_count)
            0: begin
                output_data = iteration_byte;
                ser_ready   = 1'b0;
            end
            1: begin
                output_data = cycle_counter[15:8];
                ser_ready   = 1'b0;
            end
            2: begin
                output_data = cycle_counter[7:0];
                ser_ready   = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

//--- tb.f
rtl/decoder_pkg.sv
rtl/fifo_wrapper.sv
rtl/serializer.sv
rtl/unified_controller.sv
rtl/decoder_control_top.sv
verification/decoder_checker.sv
verification/result_monitor.sv
verification/tb_top.sv

//--- verification/decoder_checker.sv
module decoder_checker (
    input logic                       clk,
    input logic                       reset,
    input logic                       input_ready,
    input logic                       output_valid,
    input logic                       output_ready,
    input decoder_pkg::byte_t         output_data,
    input decoder_pkg::global_stage_t global_stage
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failures = 0;  // failed assertions so far

    // host may only send in idle and while a round is being collected
    ready_rule: assert property (@(posedge clk)
        input_ready == (!reset && (global_stage == decoder_pkg::idle ||
                                   global_stage == decoder_pkg::measurement_preparing)))
        else begin
            $error("input_ready does not follow the stage");
            failures++;
        end

    output_hold: assert property (@(posedge clk) disable iff (reset)
        output_valid && !output_ready |=> output_valid && $stable(output_data))
        else begin
            $error("output byte changed or dropped while back-pressured");
            failures++;
        end

    valid_after_reset: assert property (@(posedge clk) reset |=> !output_valid)
        else begin
            $error("output_valid high right after reset");
            failures++;
        end

    stage_legal: assert property (@(posedge clk) disable iff (reset)
        global_stage inside {decoder_pkg::idle, decoder_pkg::parameters_loading,
                             decoder_pkg::measurement_preparing,
                             decoder_pkg::measurement_loading, decoder_pkg::grow,
                             decoder_pkg::merge, decoder_pkg::peeling,
                             decoder_pkg::streaming_correction, decoder_pkg::result_valid})
        else begin
            $error("global_stage holds a value outside the stage enum");
            failures++;
        end

endmodule

bind decoder_control_top decoder_checker u_checker (.*);

//--- verification/result_monitor.sv
module result_monitor #(
    parameter int pu_count         = 20,
    parameter int correction_width = 11,
    parameter int maximum_delay    = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  decoder_pkg::byte_t          input_data,
    input  logic                        input_valid,
    input  logic                        input_ready,
    input  decoder_pkg::byte_t          output_data,
    input  logic                        output_valid,
    input  logic                        output_ready,
    input  logic [pu_count-1:0]         busy_pe,
    input  logic [7:0]                  measurements,
    input  logic [correction_width-1:0] correction,
    input  decoder_pkg::global_stage_t  global_stage,
    input  int                          expected_iterations,
    output int                          error_count,
    output int                          output_count
);
    timeunit 1ns;
    timeprecision 100ps;

    decoder_pkg::byte_t         expected_bytes[$];  // header and correction bytes in send order
    decoder_pkg::global_stage_t prev_stage;
    decoder_pkg::global_stage_t next_from_idle;
    decoder_pkg::byte_t         prev_byte;
    decoder_pkg::byte_t         last_measurement;
    decoder_pkg::byte_t         expected;
    logic                       prev_fire;
    logic                       busy_last;       // OR of busy_pe one cycle back
    logic                       busy_seen;       // the DUT's registered busy flag in this cycle
    logic                       prev_busy_seen;
    logic [15:0]                padded;
    int                         stage_cycles;
    int                         cycle_model;

    initial begin
        error_count  = 0;
        output_count = 0;
    end

    task automatic flag_error(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    // negedge sampling sees every port settled for the coming rising edge
    always @(negedge clk) begin
        prev_busy_seen = busy_seen;
        busy_seen      = busy_last;
        busy_last      = |busy_pe;
        if (reset) begin
            prev_stage   = decoder_pkg::idle;
            prev_fire    = 1'b0;
            stage_cycles = 0;
            cycle_model  = 0;
            expected_bytes.delete();
        end else begin
            // idle leaves only on one of the two message codes
            if (prev_stage == decoder_pkg::idle) begin
                next_from_idle = decoder_pkg::idle;
                if (prev_fire && prev_byte == decoder_pkg::start_decoding_msg) begin
                    next_from_idle = decoder_pkg::parameters_loading;
                end else if (prev_fire && prev_byte == decoder_pkg::measurement_data_header) begin
                    next_from_idle = decoder_pkg::measurement_preparing;
                end
                if (global_stage !== next_from_idle) begin
                    flag_error($sformatf("stage %s after idle, expected %s",
                                         global_stage.name(), next_from_idle.name()));
                end
            end
            if (prev_stage == decoder_pkg::parameters_loading &&
                global_stage !== decoder_pkg::idle) begin
                flag_error($sformatf("stage %s after parameters_loading", global_stage.name()));
            end
            if (global_stage == decoder_pkg::measurement_preparing &&
                input_valid && input_ready) begin
                last_measurement = input_data;
            end
            if (global_stage == decoder_pkg::measurement_loading &&
                measurements !== last_measurement) begin
                flag_error($sformatf("measurements %h, expected %h",
                                     measurements, last_measurement));
            end
            if ((prev_stage == decoder_pkg::merge || prev_stage == decoder_pkg::peeling) &&
                global_stage != prev_stage) begin
                if (stage_cycles < maximum_delay + 1) begin
                    flag_error($sformatf("%s lasted %0d cycles", prev_stage.name(), stage_cycles));
                end
                if (prev_busy_seen !== 1'b0) begin
                    flag_error($sformatf("%s left while the array was busy", prev_stage.name()));
                end
            end
            stage_cycles = (global_stage == prev_stage) ? stage_cycles + 1 : 1;
            if (global_stage == decoder_pkg::measurement_loading) begin
                cycle_model = 1;
            end else if (global_stage inside {decoder_pkg::grow, decoder_pkg::merge,
                                              decoder_pkg::peeling}) begin
                cycle_model++;
            end
            if (global_stage == decoder_pkg::streaming_correction) begin
                expected_bytes.push_back(decoder_pkg::byte_t'(expected_iterations));
                expected_bytes.push_back(cycle_model[15:8]);
                expected_bytes.push_back(cycle_model[7:0]);
            end
            if (prev_stage == decoder_pkg::result_valid) begin
                padded = 16'(correction);  // the array answers one cycle after result_valid
                expected_bytes.push_back(padded[7:0]);
                expected_bytes.push_back(padded[15:8]);
            end
            if (output_valid && output_ready) begin
                if (expected_bytes.size() == 0) begin
                    flag_error($sformatf("output byte %h arrived with none expected", output_data));
                end else begin
                    expected = expected_bytes.pop_front();
                    if (output_data !== expected) begin
                        flag_error($sformatf("output byte %0d of its decode is %h, expected %h",
                                             output_count % 7, output_data, expected));
                    end
                end
                output_count++;
            end
            prev_stage = global_stage;
            prev_fire  = input_valid && input_ready;
            prev_byte  = input_data;
        end
    end

endmodule

//--- verification/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pu_count         = 20;
    localparam int correction_width = 11;
    localparam int decodes          = 40;
    localparam int bytes_per_decode = 7;
    localparam int cycle_limit      = decodes * 300 + 100;

    logic                        clk;
    logic                        reset;
    decoder_pkg::byte_t          input_data;
    logic                        input_valid;
    logic                        input_ready;
    decoder_pkg::byte_t          output_data;
    logic                        output_valid;
    logic                        output_ready;
    logic [pu_count-1:0]         busy_pe;
    logic [pu_count-1:0]         odd_clusters_pe;
    logic [7:0]                  measurements;
    logic [correction_width-1:0] correction;
    decoder_pkg::global_stage_t  global_stage;
    decoder_pkg::global_stage_t  last_stage;
    logic [31:0]                 rng_state;
    logic                        odd_active;
    int                          expected_iterations;
    int                          grow_entries;
    int                          busy_left;
    int                          busy_bit;
    int                          error_count;
    int                          output_count;
    int                          cycle_count;

    decoder_control_top u_dut (.*);

    result_monitor #(
        .pu_count(pu_count),
        .correction_width(correction_width),
        .maximum_delay(2)
    ) u_monitor (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // the upper half of the state is the better mixed part
    function automatic int draw(input int range);
        rng_state = lcg_next(rng_state);
        return int'(rng_state[31:16]) % range;
    endfunction

    // one clock, then the array model and the per-cycle random inputs
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (global_stage == decoder_pkg::grow && last_stage != decoder_pkg::grow) begin
            grow_entries++;
            if (grow_entries >= expected_iterations) begin
                odd_active = 1'b0;  // no odd cluster left, merge moves on to peeling
            end
            busy_left = draw(7);
            busy_bit  = draw(pu_count);
        end
        last_stage = global_stage;
        busy_pe    = (busy_left > 0) ? pu_count'(1) << busy_bit : '0;
        if (busy_left > 0) begin
            busy_left--;
        end
        odd_clusters_pe = odd_active ? pu_count'(1) << draw(pu_count) : '0;
        correction      = correction_width'(draw(1 << correction_width));
        output_ready    = (draw(4) != 0);
    endtask

    task automatic send_byte(input decoder_pkg::byte_t value);
        logic accepted;
        repeat (draw(3)) begin
            next_cycle();
        end
        input_data  = value;
        input_valid = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            accepted = input_ready;  // the byte moves on the coming edge
            next_cycle();
        end
        input_valid = 1'b0;
    endtask

    initial begin
        decoder_pkg::byte_t junk;
        rng_state           = 32'h40078a2a;
        reset               = 1'b1;
        input_data          = '0;
        input_valid         = 1'b0;
        output_ready        = 1'b0;
        busy_pe             = '0;
        odd_clusters_pe     = '0;
        correction          = '0;
        last_stage          = decoder_pkg::idle;
        odd_active          = 1'b0;
        expected_iterations = 0;
        grow_entries        = 0;
        busy_left           = 0;
        busy_bit            = 0;
        repeat (8) begin
            next_cycle();
        end
        reset = 1'b0;
        for (int d = 0; d < decodes; d++) begin
            expected_iterations = 1 + draw(4);
            grow_entries        = 0;
            odd_active          = 1'b1;
            repeat (draw(4)) begin
                junk = decoder_pkg::byte_t'(3 + draw(253));  // never one of the two codes
                send_byte(junk);
            end
            if (draw(4) == 0) begin
                send_byte(decoder_pkg::start_decoding_msg);
            end
            send_byte(decoder_pkg::measurement_data_header);
            repeat (2) begin
                send_byte(decoder_pkg::byte_t'(draw(256)));
            end
            while (output_count < bytes_per_decode * (d + 1)) begin
                next_cycle();
            end
        end
        repeat (10) begin
            next_cycle();
        end
        $display("closing: %0d monitor errors, %0d assertion failures",
                 error_count, u_dut.u_checker.failures);
        if (error_count == 0 && u_dut.u_checker.failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
